// ==== verilog/cpuTypesPkg.sv ====
// CPU shared types and encodings
`default_nettype none

package cpuTypesPkg;

  // ##############################
  // Widths
  // ##############################
  typedef logic [31:0] wordT;    // Data word, instruction or PC
  typedef logic [4:0]  regAddrT; // Register index

  typedef enum logic [2:0]
  {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } aluOpT;

  // ##############################
  // Opcodes
  // ##############################
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0a;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_XORI  = 6'h0e;
  localparam logic [5:0] OP_LUI   = 6'h0f;

  // R-type function codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  localparam wordT RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== verilog/fetchUnit.sv ====
// Instruction fetch unit
`timescale 1ns/100ps
`default_nettype none

module fetchUnit
(
  input  logic               CLK,
  input  logic               nRST,
  output logic               imemReq,
  output cpuTypesPkg::wordT  imemAddr,
  input  logic               imemAck,
  input  cpuTypesPkg::wordT  imemData,
  input  logic               redirect,
  input  cpuTypesPkg::wordT  redirectPc,
  output logic               instrLoad,
  output cpuTypesPkg::wordT  instrWord,
  output cpuTypesPkg::wordT  instrPc
);

  typedef enum logic [1:0]
  {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_RELEASE
  } fetchStateT;

  fetchStateT        state;
  cpuTypesPkg::wordT pc;      // Next address to fetch
  cpuTypesPkg::wordT reqAddr; // Address held for the request in flight
  cpuTypesPkg::wordT fetchPc;
  logic              stale;   // Outstanding fetch belongs to a flushed path

  assign fetchPc = redirect ? redirectPc : pc;

  assign imemReq   = (state == FETCH_REQ);
  assign imemAddr  = reqAddr;
  assign instrLoad = (state == FETCH_REQ) && imemAck && !stale;
  assign instrWord = imemData;
  assign instrPc   = reqAddr;

  // ##############################
  // Four-phase handshake
  // ##############################
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state   <= FETCH_IDLE;
      pc      <= cpuTypesPkg::RESET_PC;
      reqAddr <= cpuTypesPkg::RESET_PC;
      stale   <= 1'b0;
    end
    else
    begin
      case (state)
        FETCH_IDLE, FETCH_RELEASE:
          if (!imemAck) // Memory has released, start the next request
          begin
            state   <= FETCH_REQ;
            reqAddr <= fetchPc;
          end
        FETCH_REQ:
          if (imemAck)
          begin
            state <= FETCH_RELEASE;
            stale <= 1'b0;
          end
          else if (redirect)
            stale <= 1'b1;
        default:
          state <= FETCH_IDLE;
      endcase

      if (redirect)
        pc <= redirectPc;
      else if (instrLoad)
        pc <= pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pipeRegIfId.sv ====
// IF/ID pipeline register
`timescale 1ns/100ps
`default_nettype none

module pipeRegIfId
(
  input  logic               CLK,
  input  logic               nRST,
  input  logic               instrLoad,
  input  logic               flush,
  input  cpuTypesPkg::wordT  instrWord,
  input  cpuTypesPkg::wordT  instrPc,
  output logic               ifidValid,
  output cpuTypesPkg::wordT  ifidInstr,
  output cpuTypesPkg::wordT  ifidPc
);

  // An instruction stays valid for exactly one cycle
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      ifidValid <= 1'b0;
    else
      ifidValid <= instrLoad && !flush;
  end

  always_ff @(posedge CLK)
  begin
    if (instrLoad)
    begin
      ifidInstr <= instrWord;
      ifidPc    <= instrPc;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decodeUnit.sv ====
// Instruction decoder
`timescale 1ns/100ps
`default_nettype none

module decodeUnit
(
  input  logic                  ifidValid,
  input  cpuTypesPkg::wordT     ifidInstr,
  input  cpuTypesPkg::wordT     ifidPc,
  output cpuTypesPkg::regAddrT  rsAddr,
  output cpuTypesPkg::regAddrT  rtAddr,
  input  cpuTypesPkg::wordT     rdat1,
  input  cpuTypesPkg::wordT     rdat2,
  output cpuTypesPkg::regAddrT  regDst,
  output logic                  wen,
  output logic                  aluSrc,
  output cpuTypesPkg::aluOpT    aluOp,
  output logic                  lui,
  output logic                  branch,
  output logic                  bne,
  output logic                  jmp,
  output logic [4:0]            shamt,
  output cpuTypesPkg::wordT     imm,
  output cpuTypesPkg::wordT     decRdat1,
  output cpuTypesPkg::wordT     decRdat2,
  output logic                  decValid,
  output cpuTypesPkg::wordT     decPc
);

  logic [5:0]        opcode;
  logic [5:0]        funct;
  cpuTypesPkg::wordT immSext;
  cpuTypesPkg::wordT immZext;

  assign opcode  = ifidInstr[31:26];
  assign funct   = ifidInstr[5:0];
  assign immSext = {{16{ifidInstr[15]}}, ifidInstr[15:0]};
  assign immZext = {16'h0000, ifidInstr[15:0]};

  assign rsAddr   = ifidInstr[25:21];
  assign rtAddr   = ifidInstr[20:16];
  assign shamt    = ifidInstr[10:6];
  assign decRdat1 = rdat1;
  assign decRdat2 = rdat2;
  assign decValid = ifidValid;
  assign decPc    = ifidPc;

  always_comb
  begin
    regDst = ifidInstr[20:16]; // I-type writes rt
    wen    = 1'b0;
    aluSrc = 1'b1;
    aluOp  = cpuTypesPkg::ALU_ADD;
    lui    = 1'b0;
    branch = 1'b0;
    bne    = 1'b0;
    jmp    = 1'b0;
    imm    = immSext;
    case (opcode)
      cpuTypesPkg::OP_RTYPE:
      begin
        regDst = ifidInstr[15:11];
        aluSrc = 1'b0;
        wen    = 1'b1;
        case (funct)
          cpuTypesPkg::FN_SLL:  aluOp = cpuTypesPkg::ALU_SLL;
          cpuTypesPkg::FN_SRL:  aluOp = cpuTypesPkg::ALU_SRL;
          cpuTypesPkg::FN_ADDU: aluOp = cpuTypesPkg::ALU_ADD;
          cpuTypesPkg::FN_SUBU: aluOp = cpuTypesPkg::ALU_SUB;
          cpuTypesPkg::FN_AND:  aluOp = cpuTypesPkg::ALU_AND;
          cpuTypesPkg::FN_OR:   aluOp = cpuTypesPkg::ALU_OR;
          cpuTypesPkg::FN_XOR:  aluOp = cpuTypesPkg::ALU_XOR;
          cpuTypesPkg::FN_SLT:  aluOp = cpuTypesPkg::ALU_SLT;
          default:              wen   = 1'b0;
        endcase
      end
      cpuTypesPkg::OP_ADDIU: wen = 1'b1;
      cpuTypesPkg::OP_SLTI:
      begin
        wen   = 1'b1;
        aluOp = cpuTypesPkg::ALU_SLT;
      end
      cpuTypesPkg::OP_ANDI:
      begin
        wen   = 1'b1;
        aluOp = cpuTypesPkg::ALU_AND;
        imm   = immZext;
      end
      cpuTypesPkg::OP_ORI:
      begin
        wen   = 1'b1;
        aluOp = cpuTypesPkg::ALU_OR;
        imm   = immZext;
      end
      cpuTypesPkg::OP_XORI:
      begin
        wen   = 1'b1;
        aluOp = cpuTypesPkg::ALU_XOR;
        imm   = immZext;
      end
      cpuTypesPkg::OP_LUI:
      begin
        wen = 1'b1;
        lui = 1'b1;
        imm = immZext;
      end
      cpuTypesPkg::OP_BEQ, cpuTypesPkg::OP_BNE:
      begin
        branch = 1'b1;
        bne    = (opcode == cpuTypesPkg::OP_BNE);
        aluSrc = 1'b0; // Compare rs against rt
        aluOp  = cpuTypesPkg::ALU_SUB;
      end
      cpuTypesPkg::OP_J:
      begin
        jmp = 1'b1;
        imm = {6'h00, ifidInstr[25:0]};
      end
      default: ; // Unknown encodings fall through as a NOP
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
// Register file with write-through
`timescale 1ns/100ps
`default_nettype none

module regFile
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpuTypesPkg::regAddrT  rsAddr,
  input  cpuTypesPkg::regAddrT  rtAddr,
  input  cpuTypesPkg::regAddrT  wbReg,
  input  logic                  wbEn,
  input  cpuTypesPkg::wordT     wbData,
  output cpuTypesPkg::wordT     rdat1,
  output cpuTypesPkg::wordT     rdat2
);

  cpuTypesPkg::wordT regs [32];
  logic              wrLive;

  assign wrLive = wbEn && (wbReg != 5'd0);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wrLive)
      regs[wbReg] <= wbData;
  end

  // Same-cycle write is seen by decode, so no forwarding is needed
  assign rdat1 = (wrLive && wbReg == rsAddr) ? wbData : regs[rsAddr];
  assign rdat2 = (wrLive && wbReg == rtAddr) ? wbData : regs[rtAddr];

endmodule

`default_nettype wire

// ==== verilog/pipeRegIdEx.sv ====
// ID/EX pipeline register
`timescale 1ns/100ps
`default_nettype none

module pipeRegIdEx
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  decValid,
  input  cpuTypesPkg::wordT     decPc,
  input  cpuTypesPkg::regAddrT  regDst,
  input  logic                  wen,
  input  logic                  aluSrc,
  input  cpuTypesPkg::aluOpT    aluOp,
  input  logic                  lui,
  input  logic                  branch,
  input  logic                  bne,
  input  logic                  jmp,
  input  logic [4:0]            shamt,
  input  cpuTypesPkg::wordT     imm,
  input  cpuTypesPkg::wordT     decRdat1,
  input  cpuTypesPkg::wordT     decRdat2,
  output logic                  exValid,
  output cpuTypesPkg::wordT     exPc,
  output cpuTypesPkg::regAddrT  exRegDst,
  output logic                  exWen,
  output logic                  exAluSrc,
  output cpuTypesPkg::aluOpT    exAluOp,
  output logic                  exLui,
  output logic                  exBranch,
  output logic                  exBne,
  output logic                  exJmp,
  output logic [4:0]            exShamt,
  output cpuTypesPkg::wordT     exImm,
  output cpuTypesPkg::wordT     exRdat1,
  output cpuTypesPkg::wordT     exRdat2
);

  // ##############################
  // Controls cleared on flush
  // ##############################
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      exValid  <= 1'b0;
      exWen    <= 1'b0;
      exBranch <= 1'b0;
      exBne    <= 1'b0;
      exJmp    <= 1'b0;
    end
    else if (flush)
    begin
      exValid  <= 1'b0;
      exWen    <= 1'b0;
      exBranch <= 1'b0;
      exBne    <= 1'b0;
      exJmp    <= 1'b0;
    end
    else
    begin
      exValid  <= decValid;
      exWen    <= wen;
      exBranch <= branch;
      exBne    <= bne;
      exJmp    <= jmp;
    end
  end

  always_ff @(posedge CLK)
  begin
    exPc     <= decPc;
    exRegDst <= regDst;
    exAluSrc <= aluSrc;
    exAluOp  <= aluOp;
    exLui    <= lui;
    exShamt  <= shamt;
    exImm    <= imm;
    exRdat1  <= decRdat1;
    exRdat2  <= decRdat2;
  end

endmodule

`default_nettype wire

// ==== verilog/execUnit.sv ====
// Execute and writeback stage
`timescale 1ns/100ps
`default_nettype none

module execUnit
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  exValid,
  input  cpuTypesPkg::wordT     exPc,
  input  cpuTypesPkg::regAddrT  exRegDst,
  input  logic                  exWen,
  input  logic                  exAluSrc,
  input  cpuTypesPkg::aluOpT    exAluOp,
  input  logic                  exLui,
  input  logic                  exBranch,
  input  logic                  exBne,
  input  logic                  exJmp,
  input  logic [4:0]            exShamt,
  input  cpuTypesPkg::wordT     exImm,
  input  cpuTypesPkg::wordT     exRdat1,
  input  cpuTypesPkg::wordT     exRdat2,
  output logic                  redirect,
  output cpuTypesPkg::wordT     redirectPc,
  output logic                  wbEn,
  output cpuTypesPkg::regAddrT  wbReg,
  output cpuTypesPkg::wordT     wbData,
  output logic                  wbValid,
  output cpuTypesPkg::regAddrT  wbRegOut,
  output cpuTypesPkg::wordT     wbDataOut
);

  cpuTypesPkg::wordT opB;
  cpuTypesPkg::wordT aluOut;
  cpuTypesPkg::wordT pcPlus4;
  cpuTypesPkg::wordT branchTarget;
  cpuTypesPkg::wordT jumpTarget;
  logic              takeBranch;

  assign opB = exAluSrc ? exImm : exRdat2;

  always_comb
  begin
    case (exAluOp)
      cpuTypesPkg::ALU_SLL: aluOut = opB << exShamt;
      cpuTypesPkg::ALU_SRL: aluOut = opB >> exShamt;
      cpuTypesPkg::ALU_ADD: aluOut = exRdat1 + opB;
      cpuTypesPkg::ALU_SUB: aluOut = exRdat1 - opB;
      cpuTypesPkg::ALU_AND: aluOut = exRdat1 & opB;
      cpuTypesPkg::ALU_OR:  aluOut = exRdat1 | opB;
      cpuTypesPkg::ALU_XOR: aluOut = exRdat1 ^ opB;
      default:              aluOut = {31'd0, $signed(exRdat1) < $signed(opB)}; // Signed SLT
    endcase
  end

  // ##############################
  // Branch and jump resolution
  // ##############################
  assign pcPlus4      = exPc + 32'd4;
  assign branchTarget = pcPlus4 + {exImm[29:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], exImm[25:0], 2'b00};
  assign takeBranch   = exBranch && ((aluOut == 32'd0) != exBne);

  assign redirect   = exValid && (exJmp || takeBranch);
  assign redirectPc = exJmp ? jumpTarget : branchTarget;

  // Register file write, seen by decode in this same cycle
  assign wbEn   = exValid && exWen && (exRegDst != 5'd0);
  assign wbReg  = exRegDst;
  assign wbData = exLui ? {exImm[15:0], 16'h0000} : aluOut;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      wbValid <= 1'b0;
    else
      wbValid <= wbEn;
  end

  always_ff @(posedge CLK)
  begin
    wbRegOut  <= wbReg;
    wbDataOut <= wbData;
  end

endmodule

`default_nettype wire

// ==== verilog/miniPipeCpu.sv ====
// Three-stage pipeline top level
`timescale 1ns/100ps
`default_nettype none

module miniPipeCpu
(
  input  logic                  CLK,
  input  logic                  nRST,
  output logic                  imemReq,
  output cpuTypesPkg::wordT     imemAddr,
  input  logic                  imemAck,
  input  cpuTypesPkg::wordT     imemData,
  output logic                  wbValid,
  output cpuTypesPkg::regAddrT  wbReg,
  output cpuTypesPkg::wordT     wbData
);

  logic                 instrLoad, redirect;
  cpuTypesPkg::wordT    instrWord, instrPc, redirectPc;
  logic                 ifidValid;
  cpuTypesPkg::wordT    ifidInstr, ifidPc;
  cpuTypesPkg::regAddrT rsAddr, rtAddr;
  cpuTypesPkg::wordT    rdat1, rdat2;
  // Decode outputs
  cpuTypesPkg::regAddrT regDst;
  logic                 wen, aluSrc, lui, branch, bne, jmp, decValid;
  cpuTypesPkg::aluOpT   aluOp;
  logic [4:0]           shamt;
  cpuTypesPkg::wordT    imm, decRdat1, decRdat2, decPc;
  // ID/EX outputs
  cpuTypesPkg::regAddrT exRegDst;
  logic                 exValid, exWen, exAluSrc, exLui, exBranch, exBne, exJmp;
  cpuTypesPkg::aluOpT   exAluOp;
  logic [4:0]           exShamt;
  cpuTypesPkg::wordT    exPc, exImm, exRdat1, exRdat2;
  // Register file write port
  logic                 rfWen;
  cpuTypesPkg::regAddrT rfWreg;
  cpuTypesPkg::wordT    rfWdata;

  fetchUnit u_fetchUnit (.CLK, .nRST, .imemReq, .imemAddr, .imemAck, .imemData,
    .redirect, .redirectPc, .instrLoad, .instrWord, .instrPc);

  pipeRegIfId u_pipeRegIfId (.CLK, .nRST, .instrLoad, .flush(redirect),
    .instrWord, .instrPc, .ifidValid, .ifidInstr, .ifidPc);

  decodeUnit u_decodeUnit (.ifidValid, .ifidInstr, .ifidPc, .rsAddr, .rtAddr,
    .rdat1, .rdat2, .regDst, .wen, .aluSrc, .aluOp, .lui, .branch, .bne, .jmp,
    .shamt, .imm, .decRdat1, .decRdat2, .decValid, .decPc);

  regFile u_regFile (.CLK, .nRST, .rsAddr, .rtAddr, .wbReg(rfWreg), .wbEn(rfWen),
    .wbData(rfWdata), .rdat1, .rdat2);

  pipeRegIdEx u_pipeRegIdEx (.CLK, .nRST, .flush(redirect), .decValid, .decPc,
    .regDst, .wen, .aluSrc, .aluOp, .lui, .branch, .bne, .jmp, .shamt, .imm,
    .decRdat1, .decRdat2, .exValid, .exPc, .exRegDst, .exWen, .exAluSrc,
    .exAluOp, .exLui, .exBranch, .exBne, .exJmp, .exShamt, .exImm, .exRdat1,
    .exRdat2);

  execUnit u_execUnit (.CLK, .nRST, .exValid, .exPc, .exRegDst, .exWen,
    .exAluSrc, .exAluOp, .exLui, .exBranch, .exBne, .exJmp, .exShamt, .exImm,
    .exRdat1, .exRdat2, .redirect, .redirectPc, .wbEn(rfWen), .wbReg(rfWreg),
    .wbData(rfWdata), .wbValid, .wbRegOut(wbReg), .wbDataOut(wbData));

endmodule

`default_nettype wire

// ==== bench/pipeChecker.sv ====
// Writeback checker and program model
`timescale 1ns/100ps
`default_nettype none

module pipeChecker
(
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  cpuTypesPkg::wordT     progMem [64],
  input  logic                  imemReq,
  input  logic                  imemAck,
  input  cpuTypesPkg::wordT     imemAddr,
  input  logic                  wbValid,
  input  cpuTypesPkg::regAddrT  wbReg,
  input  cpuTypesPkg::wordT     wbData,
  output logic                  testDone,
  output int                    checkCount,
  output int                    errorCount
);

  cpuTypesPkg::regAddrT expReg [$];  // Expected writes in program order
  cpuTypesPkg::wordT    expData [$];
  logic                 active;
  int                   silent;      // Cycles since the last DUT writeback
  logic                 prevReq;
  logic                 prevAck;
  cpuTypesPkg::wordT    prevAddr;

  initial
  begin
    testDone   = 1'b0;
    checkCount = 0;
    errorCount = 0;
    active     = 1'b0;
    silent     = 0;
    prevReq    = 1'b0;
    prevAck    = 1'b0;
    prevAddr   = '0;
  end

  // ##############################
  // Architectural model
  // ##############################
  task automatic runModel();
    cpuTypesPkg::wordT    regs [32];
    cpuTypesPkg::wordT    pc;
    cpuTypesPkg::wordT    nextPc;
    cpuTypesPkg::wordT    ins;
    cpuTypesPkg::wordT    rs;
    cpuTypesPkg::wordT    rt;
    cpuTypesPkg::wordT    sext;
    cpuTypesPkg::wordT    zext;
    cpuTypesPkg::wordT    res;
    cpuTypesPkg::regAddrT dst;
    logic [5:0]           op;
    logic                 wr;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    expReg.delete();
    expData.delete();
    pc = cpuTypesPkg::RESET_PC;
    // Branches only go forward, so the PC always leaves the program
    while (pc < 32'd256)
    begin
      ins    = progMem[pc[7:2]];
      op     = ins[31:26];
      rs     = regs[ins[25:21]];
      rt     = regs[ins[20:16]];
      sext   = {{16{ins[15]}}, ins[15:0]};
      zext   = {16'h0000, ins[15:0]};
      nextPc = pc + 32'd4;
      dst    = ins[20:16];
      wr     = 1'b1;
      res    = '0;
      case (op)
        cpuTypesPkg::OP_RTYPE:
        begin
          dst = ins[15:11];
          case (ins[5:0])
            cpuTypesPkg::FN_ADDU: res = rs + rt;
            cpuTypesPkg::FN_SUBU: res = rs - rt;
            cpuTypesPkg::FN_AND:  res = rs & rt;
            cpuTypesPkg::FN_OR:   res = rs | rt;
            cpuTypesPkg::FN_XOR:  res = rs ^ rt;
            cpuTypesPkg::FN_SLT:  res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
            cpuTypesPkg::FN_SLL:  res = rt << ins[10:6];
            cpuTypesPkg::FN_SRL:  res = rt >> ins[10:6];
            default:              wr  = 1'b0;
          endcase
        end
        cpuTypesPkg::OP_ADDIU: res = rs + sext;
        cpuTypesPkg::OP_SLTI:  res = ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
        cpuTypesPkg::OP_ANDI:  res = rs & zext;
        cpuTypesPkg::OP_ORI:   res = rs | zext;
        cpuTypesPkg::OP_XORI:  res = rs ^ zext;
        cpuTypesPkg::OP_LUI:   res = {ins[15:0], 16'h0000};
        cpuTypesPkg::OP_BEQ, cpuTypesPkg::OP_BNE:
        begin
          wr = 1'b0;
          if ((rs == rt) == (op == cpuTypesPkg::OP_BEQ))
            nextPc = nextPc + {sext[29:0], 2'b00};
        end
        cpuTypesPkg::OP_J:
        begin
          wr     = 1'b0;
          nextPc = {nextPc[31:28], ins[25:0], 2'b00};
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0)
      begin
        regs[dst] = res;
        expReg.push_back(dst);
        expData.push_back(res);
      end
      pc = nextPc;
    end
  endtask

  task automatic compareWrite();
    if (expReg.size() == 0)
    begin
      $display("Unexpected writeback at %0t: r%0d = %h after the program's last write",
               $time, wbReg, wbData);
      errorCount++;
    end
    else
    begin
      checkCount++;
      if (wbReg != expReg[0] || wbData != expData[0])
      begin
        $display("** Error at %0t: writeback expected r%0d = %h, got r%0d = %h",
                 $time, expReg[0], expData[0], wbReg, wbData);
        errorCount++;
      end
      void'(expReg.pop_front());
      void'(expData.pop_front());
    end
  endtask

  // Four-phase handshake and address rules of the fetch port
  task automatic checkFetchBus();
    if (nRST && imemReq)
    begin
      if (imemAddr[1:0] != 2'b00)
      begin
        $display("** Error at %0t: imemAddr %h is not word aligned", $time, imemAddr);
        errorCount++;
      end
      if (prevReq && imemAddr != prevAddr)
      begin
        $display("** Error at %0t: imemAddr changed from %h to %h during a request",
                 $time, prevAddr, imemAddr);
        errorCount++;
      end
      if (!prevReq && prevAck)
      begin
        $display("Handshake failure at %0t: imemReq rose before imemAck was released",
                 $time);
        errorCount++;
      end
      if (prevReq && prevAck)
      begin
        $display("Handshake failure at %0t: imemReq stayed high after imemAck", $time);
        errorCount++;
      end
    end
    prevReq  = imemReq;
    prevAck  = imemAck;
    prevAddr = imemAddr;
  endtask

  // Outputs are sampled away from the rising edge
  always @(negedge CLK)
  begin
    checkFetchBus();
    if (!nRST)
    begin
      if (imemReq || wbValid)
      begin
        $display("Reset failure at %0t: imemReq or wbValid is high while nRST is low", $time);
        errorCount++;
      end
    end
    else if (start)
    begin
      runModel();
      active   = 1'b1;
      silent   = 0;
      testDone = 1'b0;
    end
    else if (active)
    begin
      if (wbValid)
      begin
        silent = 0;
        compareWrite();
      end
      else
        silent++;
      if (expReg.size() == 0 && silent >= 20)
      begin
        testDone = 1'b1;
        active   = 1'b0;
      end
    end
    else if (wbValid)
      compareWrite(); // Nothing is running, so any write is unexpected
  end

endmodule

`default_nettype wire

// ==== bench/tbMiniPipeCpu.sv ====
// Pipeline CPU testbench
`timescale 1ns/100ps
`default_nettype none

module tbMiniPipeCpu;

  localparam int NUM_TESTS   = 5;
  localparam int PROG_WORDS  = 64;
  localparam int CYCLE_LIMIT = NUM_TESTS * PROG_WORDS * 16;

  logic                 CLK;
  logic                 nRST;
  logic                 imemReq;
  cpuTypesPkg::wordT    imemAddr;
  logic                 imemAck;
  cpuTypesPkg::wordT    imemData;
  logic                 wbValid;
  cpuTypesPkg::regAddrT wbReg;
  cpuTypesPkg::wordT    wbData;

  cpuTypesPkg::wordT    progMem [64];
  logic                 start;
  logic                 latencyOn;   // Random acknowledge delay
  logic                 pending;
  int                   waitCnt;
  int                   cycleCount = 0;
  int                   checksBefore;
  int                   errorsBefore;
  logic                 testDone;
  int                   checkCount;
  int                   errorCount;

  miniPipeCpu u_miniPipeCpu (.CLK, .nRST, .imemReq, .imemAddr, .imemAck, .imemData,
    .wbValid, .wbReg, .wbData);

  pipeChecker u_pipeChecker (.CLK, .nRST, .start, .progMem, .imemReq, .imemAck, .imemAddr,
    .wbValid, .wbReg, .wbData, .testDone, .checkCount, .errorCount);

  always #50 CLK = ~CLK;

  // ##############################
  // Program generation
  // ##############################
  function automatic cpuTypesPkg::wordT encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] rd, input logic [4:0] sh,
                                                input logic [5:0] fn);
    return {cpuTypesPkg::OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic cpuTypesPkg::wordT encodeI(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [4:0] pickReg();
    return 5'($urandom_range(0, 7)); // A small set keeps dependences close together
  endfunction

  function automatic cpuTypesPkg::wordT randomRType();
    logic [5:0] fn;
    logic [4:0] sh;
    logic [4:0] rs;
    sh = '0;
    rs = pickReg();
    case ($urandom_range(0, 7))
      0: fn = cpuTypesPkg::FN_ADDU;
      1: fn = cpuTypesPkg::FN_SUBU;
      2: fn = cpuTypesPkg::FN_AND;
      3: fn = cpuTypesPkg::FN_OR;
      4: fn = cpuTypesPkg::FN_XOR;
      5: fn = cpuTypesPkg::FN_SLT;
      6:
      begin
        fn = cpuTypesPkg::FN_SLL;
        sh = 5'($urandom_range(0, 31));
        rs = '0;
      end
      default:
      begin
        fn = cpuTypesPkg::FN_SRL;
        sh = 5'($urandom_range(0, 31));
        rs = '0;
      end
    endcase
    return encodeR(rs, pickReg(), pickReg(), sh, fn);
  endfunction

  function automatic cpuTypesPkg::wordT randomIType();
    logic [5:0] op;
    logic [4:0] rs;
    rs = pickReg();
    case ($urandom_range(0, 5))
      0: op = cpuTypesPkg::OP_ADDIU;
      1: op = cpuTypesPkg::OP_ANDI;
      2: op = cpuTypesPkg::OP_ORI;
      3: op = cpuTypesPkg::OP_XORI;
      4: op = cpuTypesPkg::OP_SLTI;
      default:
      begin
        op = cpuTypesPkg::OP_LUI;
        rs = '0;
      end
    endcase
    return encodeI(op, rs, pickReg(), 16'($urandom()));
  endfunction

  // Forward by 1 to 6 words from the word at idx
  function automatic cpuTypesPkg::wordT randomBranch(input int idx);
    int                skip;
    cpuTypesPkg::wordT ins;
    skip = int'($urandom_range(1, 6));
    case ($urandom_range(0, 2))
      0:       ins = encodeI(cpuTypesPkg::OP_BEQ, pickReg(), pickReg(), 16'(skip - 1));
      1:       ins = encodeI(cpuTypesPkg::OP_BNE, pickReg(), pickReg(), 16'(skip - 1));
      default: ins = {cpuTypesPkg::OP_J, 26'(idx + skip)};
    endcase
    return ins;
  endfunction

  // Kind 0 is R-type, 1 is immediate, 2 is a mix with branches and jumps
  task automatic buildProgram(input int kind);
    int pick;
    for (int i = 0; i < PROG_WORDS; i++)
    begin
      pick = int'($urandom_range(0, 9));
      if (kind != 1 && i < 8)
        progMem[i] = encodeI(cpuTypesPkg::OP_ADDIU, 5'd0, 5'(i), 16'($urandom()));
      else if (kind == 0 || (kind == 2 && pick < 5))
        progMem[i] = randomRType();
      else if (kind == 1 || pick < 8)
        progMem[i] = randomIType();
      else
        progMem[i] = randomBranch(i);
    end
  endtask

  function automatic cpuTypesPkg::wordT readWord(input cpuTypesPkg::wordT addr);
    if (addr[31:8] != 24'd0)
      return '0; // Past the program reads as a NOP
    return progMem[addr[7:2]];
  endfunction

  function automatic string testName(input int t);
    string name;
    case (t)
      0:       name = "R-type, no latency";
      1:       name = "immediate, no latency";
      2:       name = "branches, no latency";
      3:       name = "branches, random latency";
      default: name = "mixed, random latency";
    endcase
    return name;
  endfunction

  task automatic applyReset();
    @(posedge CLK);
    #1;
    nRST = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
  endtask

  // ##############################
  // Instruction memory responder
  // ##############################
  always @(posedge CLK)
  begin
    #1;
    if (!nRST)
    begin
      imemAck = 1'b0;
      pending = 1'b0;
    end
    else if (imemAck)
    begin
      if (!imemReq)
        imemAck = 1'b0;
    end
    else if (imemReq)
    begin
      if (!pending)
      begin
        pending = 1'b1;
        waitCnt = latencyOn ? int'($urandom_range(0, 4)) : 0;
      end
      if (waitCnt == 0)
      begin
        imemAck  = 1'b1;
        imemData = readWord(imemAddr);
        pending  = 1'b0;
      end
      else
        waitCnt--;
    end
  end

  always @(posedge CLK)
  begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(40));
    CLK       = 1'b0;
    nRST      = 1'b0;
    imemAck   = 1'b0;
    imemData  = '0;
    start     = 1'b0;
    latencyOn = 1'b0;
    pending   = 1'b0;
    waitCnt   = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      if (t != 3) // Test 3 replays the branch program with slow memory
        buildProgram((t < 2) ? t : 2);
      latencyOn    = (t >= 3);
      checksBefore = checkCount;
      errorsBefore = errorCount;
      applyReset();
      start = 1'b1;
      @(posedge CLK);
      #1;
      start = 1'b0;
      wait (testDone);
      $display("Test %0d (%s): %0d writebacks checked, %0d errors", t, testName(t),
               checkCount - checksBefore, errorCount - errorsBefore);
    end
    $display("Summary: %0d tests, %0d writebacks checked, %0d errors", NUM_TESTS,
             checkCount, errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== miniPipeCpu.f ====
verilog/cpuTypesPkg.sv
verilog/fetchUnit.sv
verilog/pipeRegIfId.sv
verilog/decodeUnit.sv
verilog/regFile.sv
verilog/pipeRegIdEx.sv
verilog/execUnit.sv
verilog/miniPipeCpu.sv
bench/pipeChecker.sv
bench/tbMiniPipeCpu.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tbMiniPipeCpu \
  -f miniPipeCpu.f -o simMiniPipeCpu \
  && ./obj_dir/simMiniPipeCpu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; } || exit 0
